/* hw/cache_settings.svh */
// Size settings for the direct-mapped data cache array
// Included by the package and by every module that sizes a port from these macros

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Total data capacity and line size, both in bytes
`define CACHE_SIZE_BYTES 8192
`define BLOCK_SIZE_BYTES 16

// Tag, index, bank select and the 2 byte bits must sum to 32
`define TAG_BITS 19

// One word-wide bank per word of a line
`define DATA_BANKS (`BLOCK_SIZE_BYTES / 4)

// Bank select width inside a line
`define OFFSET_BITS ($clog2(`DATA_BANKS))

// Line index width
`define INDEX_BITS ($clog2(`CACHE_SIZE_BYTES / `BLOCK_SIZE_BYTES))

`endif

/* hw/cache_pkg.sv */
// Shared word, mask and address field types for the data cache array
// Modules import it in their body and use scoped names on their ports

`include "cache_settings.svh"

package cache_pkg;

    //============================================================
    // Data path types
    //============================================================

    // One data word, also used for full byte addresses
    typedef logic [31:0] data_word_t;

    // One enable per byte lane of a word
    typedef logic [3:0] byte_mask_t;

    //============================================================
    // Address field types
    //============================================================

    // Upper address bits stored per line
    typedef logic [`TAG_BITS-1:0] cache_tag_t;

    // Selects one line of the array
    typedef logic [`INDEX_BITS-1:0] line_index_t;

    // Selects one word (bank) inside a line
    typedef logic [`OFFSET_BITS-1:0] bank_sel_t;

endpackage : cache_pkg

/* hw/bank_write_steer.sv */
// Write strobe decoder for the data banks of the cache array
// Only the bank named by the write address sees the data write strobe

`timescale 1ns/1ps

`include "cache_settings.svh"

module bank_write_steer (
    // Data write strobe from the caller
    input  logic                     data_write_i,
    // Bank select field of the write address
    input  cache_pkg::bank_sel_t     write_bank_i,
    // One strobe per data bank
    output logic [`DATA_BANKS-1:0]   bank_write_o
);

    import cache_pkg::*;

    //============================================================
    // One-hot decode
    //============================================================

    // Bank number of each strobe, compared against the field
    always_comb begin
        for (int b = 0; b < `DATA_BANKS; b++) begin
            // Strobe only the addressed word of the line
            bank_write_o[b] = data_write_i && (write_bank_i == bank_sel_t'(b));
        end
    end

endmodule : bank_write_steer

/* hw/data_bank.sv */
// One word-wide bank of line storage for the data cache array
// Byte-masked writes, one-cycle registered read, array contents not reset

`timescale 1ns/1ps

module data_bank (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Write side
    input  logic                     bank_write_i,
    input  cache_pkg::byte_mask_t    byte_write_i,
    input  cache_pkg::line_index_t   write_index_i,
    input  cache_pkg::data_word_t    write_data_i,
    // Read side
    input  cache_pkg::line_index_t   read_index_i,
    input  logic                     read_i,
    output cache_pkg::data_word_t    bank_data_o
);

    import cache_pkg::*;

    // One entry per line
    localparam int DEPTH = 2 ** $bits(line_index_t);
    // Byte lanes per word
    localparam int LANES = $bits(byte_mask_t);

    data_word_t mem_q [DEPTH];

    // Byte lane update, lanes without a mask bit keep their value
    always_ff @(posedge clk_i) begin
        if (bank_write_i) begin
            for (int l = 0; l < LANES; l++) begin
                if (byte_write_i[l]) begin
                    mem_q[write_index_i][l*8 +: 8] <= write_data_i[l*8 +: 8];
                end
            end
        end
    end

    // Registered read, sees the contents from before a same-edge write
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bank_data_o <= '0;
        end else if (read_i) begin
            bank_data_o <= mem_q[read_index_i];
        end
    end

endmodule : data_bank

/* hw/bank_read_select.sv */
// Output mux that drains the data banks of the cache array
// Bank select is registered alongside the bank read registers

`timescale 1ns/1ps

`include "cache_settings.svh"

module bank_read_select (
    input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    // Same read strobe that the banks see
    input  logic                                        read_i,
    // Bank select field of the read address
    input  cache_pkg::bank_sel_t                        read_bank_i,
    // Registered word of every bank
    input  cache_pkg::data_word_t [`DATA_BANKS-1:0]     bank_data_i,
    output cache_pkg::data_word_t                       read_data_o
);

    import cache_pkg::*;

    // Select held until the next enabled read
    bank_sel_t read_bank_q;

    //============================================================
    // Select register
    //============================================================

    // Sampled on the same edge the banks latch their words
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_bank_q <= '0;
        end else if (read_i) begin
            read_bank_q <= read_bank_i;
        end
    end

    //============================================================
    // Word steering
    //============================================================

    // Pure mux after the registers, so latency stays one cycle
    assign read_data_o = bank_data_i[read_bank_q];

endmodule : bank_read_select

/* hw/status_memory.sv */
// Valid and dirty bits of every cache line
// One write port with separate strobes, two registered read ports, async clear

`timescale 1ns/1ps

module status_memory (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    // Write port, shared line index
    input  cache_pkg::line_index_t         write_index_i,
    input  logic                           valid_write_i,
    input  logic                           valid_i,
    input  logic                           dirty_write_i,
    input  logic                           dirty_i,
    // Read ports, 0 is the probe port and 1 the read port
    input  cache_pkg::line_index_t [1:0]   read_index_i,
    input  logic [1:0]                     valid_read_i,
    input  logic [1:0]                     dirty_read_i,
    output logic [1:0]                     valid_o,
    output logic [1:0]                     dirty_o
);

    import cache_pkg::*;

    // One bit per line in each array
    localparam int DEPTH = 2 ** $bits(line_index_t);

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] dirty_q;

    //============================================================
    // Bit arrays
    //============================================================

    // Valid array, cleared so the whole cache starts empty
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (valid_write_i) begin
            valid_q[write_index_i] <= valid_i;
        end
    end

    // Dirty array, written apart from valid
    // A refill can set valid and leave dirty alone
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dirty_q <= '0;
        end else if (dirty_write_i) begin
            dirty_q[write_index_i] <= dirty_i;
        end
    end

    //============================================================
    // Read ports
    //============================================================

    // Each port holds its bits until its next enabled read
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= '0;
            dirty_o <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (valid_read_i[p]) begin
                    valid_o[p] <= valid_q[read_index_i[p]];
                end
                if (dirty_read_i[p]) begin
                    dirty_o[p] <= dirty_q[read_index_i[p]];
                end
            end
        end
    end

endmodule : status_memory

/* hw/tag_memory.sv */
// Tag storage of the cache array, one tag per line
// One write port and two independently enabled registered read ports

`timescale 1ns/1ps

module tag_memory (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    // Write port
    input  cache_pkg::line_index_t         write_index_i,
    input  logic                           tag_write_i,
    input  cache_pkg::cache_tag_t          tag_i,
    // Read ports, 0 is the probe port and 1 the read port
    input  cache_pkg::line_index_t [1:0]   read_index_i,
    input  logic [1:0]                     tag_read_i,
    output cache_pkg::cache_tag_t [1:0]    tag_o
);

    import cache_pkg::*;

    // One tag per line
    localparam int DEPTH = 2 ** $bits(line_index_t);

    cache_tag_t tag_q [DEPTH];

    //============================================================
    // Tag array
    //============================================================

    // Contents are meaningless until valid is set for the line
    always_ff @(posedge clk_i) begin
        if (tag_write_i) begin
            tag_q[write_index_i] <= tag_i;
        end
    end

    //============================================================
    // Read ports
    //============================================================

    // Old tag is returned when a write hits the same line this edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tag_o <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (tag_read_i[p]) begin
                    tag_o[p] <= tag_q[read_index_i[p]];
                end
            end
        end
    end

endmodule : tag_memory

/* hw/data_cache.sv */
// Top of the direct-mapped write-back data cache array
// Combined write/probe port 0 and read port 1, all enables driven by the caller
// Hit, dirty and tag results appear one cycle after the enabled read

`timescale 1ns/1ps

`include "cache_settings.svh"

module data_cache (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Write and probe port
    input  cache_pkg::data_word_t     rw_address_i,
    input  logic                      data_write_i,
    input  logic                      tag_write_i,
    input  logic                      valid_write_i,
    input  logic                      dirty_write_i,
    input  cache_pkg::byte_mask_t     byte_write_i,
    input  cache_pkg::data_word_t     write_data_i,
    input  logic                      valid_i,
    input  logic                      dirty_i,
    // Read port
    input  cache_pkg::data_word_t     read_address_i,
    input  logic                      data_read_i,
    // Per-port read enables, bit 0 probe and bit 1 read
    input  logic [1:0]                tag_read_i,
    input  logic [1:0]                valid_read_i,
    input  logic [1:0]                dirty_read_i,
    // Results
    output cache_pkg::data_word_t     read_data_o,
    output cache_pkg::cache_tag_t     read_tag_o,
    output logic [1:0]                hit_o,
    output logic [1:0]                dirty_o
);

    import cache_pkg::*;

    // Bit position of the lowest index bit, above bank select and byte bits
    localparam int INDEX_LSB = 2 + `OFFSET_BITS;
    // Bit position of the lowest tag bit
    localparam int TAG_LSB = INDEX_LSB + `INDEX_BITS;

    //============================================================
    // Address split
    //============================================================

    // Layout is tag, index, bank select, then 2 ignored byte bits
    cache_tag_t  wr_tag;
    line_index_t wr_index;
    bank_sel_t   wr_bank;
    cache_tag_t  rd_tag;
    line_index_t rd_index;
    bank_sel_t   rd_bank;

    assign wr_tag   = rw_address_i[TAG_LSB +: `TAG_BITS];
    assign wr_index = rw_address_i[INDEX_LSB +: `INDEX_BITS];
    assign wr_bank  = rw_address_i[2 +: `OFFSET_BITS];

    assign rd_tag   = read_address_i[TAG_LSB +: `TAG_BITS];
    assign rd_index = read_address_i[INDEX_LSB +: `INDEX_BITS];
    assign rd_bank  = read_address_i[2 +: `OFFSET_BITS];

    //============================================================
    // Data banks
    //============================================================

    logic [`DATA_BANKS-1:0]       bank_write;
    data_word_t [`DATA_BANKS-1:0] bank_data;

    // Only the addressed word of the line is written
    bank_write_steer bank_write_steer_inst (
        .data_write_i (data_write_i),
        .write_bank_i (wr_bank),
        .bank_write_o (bank_write)
    );

    // Every bank sees the same index and data, only its strobe differs
    for (genvar b = 0; b < `DATA_BANKS; b++) begin : g_bank
        data_bank data_bank_inst (
            .clk_i         (clk_i),
            .arst_n_i      (arst_n_i),
            .bank_write_i  (bank_write[b]),
            .byte_write_i  (byte_write_i),
            .write_index_i (wr_index),
            .write_data_i  (write_data_i),
            .read_index_i  (rd_index),
            .read_i        (data_read_i),
            .bank_data_o   (bank_data[b])
        );
    end

    // Picks the read word out of the line
    bank_read_select bank_read_select_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .read_i      (data_read_i),
        .read_bank_i (rd_bank),
        .bank_data_i (bank_data),
        .read_data_o (read_data_o)
    );

    //============================================================
    // Status and tags
    //============================================================

    logic [1:0]      valid_rd;
    cache_tag_t [1:0] tag_rd;

    status_memory status_memory_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .write_index_i (wr_index),
        .valid_write_i (valid_write_i),
        .valid_i       (valid_i),
        .dirty_write_i (dirty_write_i),
        .dirty_i       (dirty_i),
        .read_index_i  ({rd_index, wr_index}),
        .valid_read_i  (valid_read_i),
        .dirty_read_i  (dirty_read_i),
        .valid_o       (valid_rd),
        .dirty_o       (dirty_o)
    );

    // Tag written always comes from the rw address
    tag_memory tag_memory_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .write_index_i (wr_index),
        .tag_write_i   (tag_write_i),
        .tag_i         (wr_tag),
        .read_index_i  ({rd_index, wr_index}),
        .tag_read_i    (tag_read_i),
        .tag_o         (tag_rd)
    );

    //============================================================
    // Hit logic
    //============================================================

    // Address tags sampled every edge, lined up with the stored tags
    cache_tag_t [1:0] cmp_tag_q;

    always_ff @(posedge clk_i) begin
        cmp_tag_q <= {rd_tag, wr_tag};
    end

    // Match on the tag and a set valid bit
    assign hit_o[0] = (cmp_tag_q[0] == tag_rd[0]) && valid_rd[0];
    assign hit_o[1] = (cmp_tag_q[1] == tag_rd[1]) && valid_rd[1];

    // Stored tag of the read port, used to build a write-back address
    assign read_tag_o = tag_rd[1];

endmodule : data_cache

/* dv/data_cache_tb.sv */
// Self-checking testbench for the data cache array
// Applies a fixed table of stimulus rows and checks the outputs one cycle later

`timescale 1ns/1ps

module data_cache_tb;

    import cache_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS = 21;

    // Tags A and B both map to line 5
    localparam cache_tag_t TAG_A = 'h12345;
    localparam cache_tag_t TAG_B = 'h00abc;
    // Tag A, line 5, banks 0 to 3
    localparam data_word_t A0 = 32'h2468_a050;
    localparam data_word_t A1 = 32'h2468_a054;
    localparam data_word_t A2 = 32'h2468_a058;
    localparam data_word_t A3 = 32'h2468_a05c;
    // Tag B at line 5 bank 0
    localparam data_word_t B0 = 32'h0157_8050;
    // Tag B at the last line and last bank
    localparam data_word_t FAR = 32'h0157_9ffc;

    // Read enables {data_read, tag_read[1:0], valid_read[1:0], dirty_read[1:0]}
    localparam logic [6:0] RD_NONE = 7'b0_00_00_00;
    localparam logic [6:0] RD_ALL = 7'b1_11_11_11;
    localparam logic [6:0] RD_HIT = 7'b1_11_11_00;
    localparam logic [6:0] RD_TAGS = 7'b0_11_11_00;

    // One row, stimulus first and expected values after
    typedef struct packed {
        data_word_t rw_addr;
        // {data_write, tag_write, valid_write, dirty_write, valid, dirty}
        logic [5:0] wr_en;
        byte_mask_t mask;
        data_word_t wdata;
        data_word_t rd_addr;
        logic [6:0] rd_en;
        data_word_t exp_data;
        cache_tag_t exp_tag;
        logic [1:0] exp_hit;
        logic [1:0] exp_dirty;
        // Compare mask {data, tag, hit, dirty}
        logic [3:0] check;
    } row_t;

    //============================================================
    // Stimulus table
    //============================================================

    localparam row_t ROWS [NUM_ROWS] = '{
        // Empty cache after reset at two addresses
        '{A0, 6'b000000, 4'h0, 32'h0, A0, RD_ALL, 32'h0, TAG_A, 2'b00, 2'b00, 4'b0011},
        '{FAR, 6'b000000, 4'h0, 32'h0, FAR, RD_ALL, 32'h0, TAG_A, 2'b00, 2'b00, 4'b0011},
        // Line fill, tag and valid go with word 0
        // Read outputs hold while no read is enabled
        '{A0, 6'b111010, 4'hf, 32'h11111111, A0, RD_NONE, 32'h0, TAG_A, 2'b00, 2'b00, 4'b0011},
        '{A1, 6'b100000, 4'hf, 32'h22222222, A0, RD_NONE, 32'h0, TAG_A, 2'b00, 2'b00, 4'b0011},
        '{A2, 6'b100000, 4'hf, 32'h33333333, A0, RD_NONE, 32'h0, TAG_A, 2'b00, 2'b00, 4'b0011},
        '{A3, 6'b100000, 4'hf, 32'h44444444, A0, RD_NONE, 32'h0, TAG_A, 2'b00, 2'b00, 4'b0011},
        // Read back each bank, probe port stays on word 0
        '{A0, 6'b000000, 4'h0, 32'h0, A0, RD_HIT, 32'h11111111, TAG_A, 2'b11, 2'b00, 4'b1110},
        '{A0, 6'b000000, 4'h0, 32'h0, A1, RD_HIT, 32'h22222222, TAG_A, 2'b11, 2'b00, 4'b1110},
        '{A0, 6'b000000, 4'h0, 32'h0, A2, RD_HIT, 32'h33333333, TAG_A, 2'b11, 2'b00, 4'b1110},
        '{A0, 6'b000000, 4'h0, 32'h0, A3, RD_HIT, 32'h44444444, TAG_A, 2'b11, 2'b00, 4'b1110},
        // Mask 0101 only touches bytes 0 and 2
        '{A1, 6'b100000, 4'h5, 32'haabbccdd, A0, RD_NONE, 32'h44444444, TAG_A, 2'b11, 2'b00, 4'b1111},
        '{A0, 6'b000000, 4'h0, 32'h0, A1, RD_HIT, 32'h22bb22dd, TAG_A, 2'b11, 2'b00, 4'b1110},
        // Same line, other tag on the read port
        '{A0, 6'b000000, 4'h0, 32'h0, B0, RD_HIT, 32'h11111111, TAG_A, 2'b01, 2'b00, 4'b1110},
        // Set dirty, then clear it and keep valid
        '{A0, 6'b000101, 4'h0, 32'h0, A0, RD_NONE, 32'h11111111, TAG_A, 2'b11, 2'b00, 4'b1111},
        '{A0, 6'b000000, 4'h0, 32'h0, A2, RD_ALL, 32'h33333333, TAG_A, 2'b11, 2'b11, 4'b1111},
        '{A0, 6'b000100, 4'h0, 32'h0, A0, RD_NONE, 32'h33333333, TAG_A, 2'b11, 2'b11, 4'b1111},
        '{A0, 6'b000000, 4'h0, 32'h0, A2, RD_ALL, 32'h33333333, TAG_A, 2'b11, 2'b00, 4'b1111},
        // Read and write of one word on one edge, old word first
        '{A3, 6'b100000, 4'hf, 32'h5a5aa5a5, A3, RD_HIT, 32'h44444444, TAG_A, 2'b11, 2'b00, 4'b1110},
        '{A0, 6'b000000, 4'h0, 32'h0, A3, RD_HIT, 32'h5a5aa5a5, TAG_A, 2'b11, 2'b00, 4'b1110},
        // Retag line 5 to B, old tag on the same edge, new tag after
        '{B0, 6'b010000, 4'h0, 32'h0, A0, RD_TAGS, 32'h0, TAG_A, 2'b10, 2'b00, 4'b0110},
        '{A0, 6'b000000, 4'h0, 32'h0, B0, RD_HIT, 32'h11111111, TAG_B, 2'b10, 2'b00, 4'b1110}
    };

    logic       clk_i = 1'b0;
    logic       arst_n_i;
    // Row currently on the DUT inputs
    row_t       cur;
    data_word_t read_data_o;
    cache_tag_t read_tag_o;
    logic [1:0] hit_o;
    logic [1:0] dirty_o;
    int         pass_count = 0;
    int         fail_count = 0;

    // 40 ns clock
    always #CLK_HALF clk_i = ~clk_i;

    data_cache data_cache_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .rw_address_i   (cur.rw_addr),
        .data_write_i   (cur.wr_en[5]),
        .tag_write_i    (cur.wr_en[4]),
        .valid_write_i  (cur.wr_en[3]),
        .dirty_write_i  (cur.wr_en[2]),
        .byte_write_i   (cur.mask),
        .write_data_i   (cur.wdata),
        .valid_i        (cur.wr_en[1]),
        .dirty_i        (cur.wr_en[0]),
        .read_address_i (cur.rd_addr),
        .data_read_i    (cur.rd_en[6]),
        .tag_read_i     (cur.rd_en[5:4]),
        .valid_read_i   (cur.rd_en[3:2]),
        .dirty_read_i   (cur.rd_en[1:0]),
        .read_data_o    (read_data_o),
        .read_tag_o     (read_tag_o),
        .hit_o          (hit_o),
        .dirty_o        (dirty_o)
    );

    //============================================================
    // Checking
    //============================================================

    // Skipped when its mask bit is clear
    task automatic compare_output(input int row, input bit enable, input string name,
                                  input logic [31:0] expected, input logic [31:0] actual,
                                  inout int errs);
        if (enable) begin
            assert (actual === expected) else begin
                $display("MISMATCH at %0t: row %0d %s expected %0h, got %0h",
                         $time, row, name, expected, actual);
                errs++;
            end
        end
    endtask

    // All masked outputs of one row, then one line for the row
    task automatic check_row(input int idx);
        row_t r;
        int   errs;
        r = ROWS[idx];
        errs = 0;
        compare_output(idx, r.check[3], "read_data_o", r.exp_data, read_data_o, errs);
        compare_output(idx, r.check[2], "read_tag_o", r.exp_tag, read_tag_o, errs);
        compare_output(idx, r.check[1], "hit_o", r.exp_hit, hit_o, errs);
        compare_output(idx, r.check[0], "dirty_o", r.exp_dirty, dirty_o, errs);
        if (errs == 0) begin
            pass_count++;
            $display("row %0d passed", idx);
        end else begin
            fail_count++;
            $display("row %0d failed with %0d mismatches", idx, errs);
        end
    endtask

    // Row i goes out on edge i, so row i-1 is settled by the next falling edge
    initial begin
        cur = '0;
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;
        for (int i = 0; i <= NUM_ROWS; i++) begin
            @(posedge clk_i);
            if (i < NUM_ROWS) begin
                cur <= ROWS[i];
            end else begin
                cur <= '0;
            end
            @(negedge clk_i);
            if (i > 0) begin
                check_row(i - 1);
            end
        end
        $display("Rows passed: %0d, rows failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Reset, every row and a margin of 10 cycles
    initial begin
        #((RESET_CYCLES + NUM_ROWS + 10) * 2 * CLK_HALF);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule : data_cache_tb

/* data_cache.f */
+incdir+hw
hw/cache_pkg.sv
hw/bank_write_steer.sv
hw/data_bank.sv
hw/bank_read_select.sv
hw/status_memory.sv
hw/tag_memory.sv
hw/data_cache.sv
dv/data_cache_tb.sv
